// File: verilog.f
+incdir+src
+incdir+tests
src/i2c_pkg.sv
src/i2c_glitch_filter.sv
src/i2c_bus_monitor.sv
src/i2c_slave_fsm.sv
src/i2c_slave.sv
tests/tb_i2c_slave.sv

// File: tests/i2c_master_tasks.svh
// ############################
// bit-banged I2C controller for the testbench
// include inside the testbench module once clk, ctl_scl,
// ctl_sda and the wired-AND pins are declared
// ############################
`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

// scl half period and sda hold after a falling scl, in clocks
localparam int half_clocks = 40;
localparam int hold_clocks = 10;
localparam int scl_timeout = 20000;

task automatic wait_clocks(input int count);
    repeat (count) @(negedge clk);
endtask

// let scl go and wait until the target stops stretching
task automatic release_scl;
    int waited;
    ctl_scl = 1'b1;
    waited = 0;
    @(negedge clk);
    while (pins.scl !== 1'b1) begin
        if (waited >= scl_timeout) begin
            abort_run("timeout: the target held scl low for too long");
        end
        @(negedge clk);
        waited++;
    end
endtask

// sda falls while scl is high
task automatic start_condition;
    wait_clocks(hold_clocks);
    ctl_sda = 1'b1;
    wait_clocks(half_clocks);
    release_scl();
    wait_clocks(half_clocks);
    ctl_sda = 1'b0;
    wait_clocks(half_clocks);
    ctl_scl = 1'b0;
endtask

// sda rises while scl is high
task automatic stop_condition;
    wait_clocks(hold_clocks);
    ctl_sda = 1'b0;
    wait_clocks(half_clocks - hold_clocks);
    release_scl();
    wait_clocks(half_clocks);
    ctl_sda = 1'b1;
    wait_clocks(half_clocks);
endtask

// eight bits MSB first, then sample the target's answer
task automatic write_byte(input logic [7:0] value, output logic ack_bit);
    for (int i = 7; i >= 0; i--) begin
        wait_clocks(hold_clocks);
        ctl_sda = value[i];
        wait_clocks(half_clocks - hold_clocks);
        release_scl();
        wait_clocks(half_clocks);
        ctl_scl = 1'b0;
    end
    // ninth clock, sda released for the ACK
    wait_clocks(hold_clocks);
    ctl_sda = 1'b1;
    wait_clocks(half_clocks - hold_clocks);
    release_scl();
    wait_clocks(half_clocks / 2);
    ack_bit = pins.sda;
    wait_clocks(half_clocks / 2);
    ctl_scl = 1'b0;
endtask

// sda sampled mid high phase; nack = 1 ends the read
task automatic read_byte(output logic [7:0] value, input logic nack);
    wait_clocks(hold_clocks);
    ctl_sda = 1'b1;
    wait_clocks(half_clocks - hold_clocks);
    for (int i = 7; i >= 0; i--) begin
        release_scl();
        wait_clocks(half_clocks / 2);
        value[i] = pins.sda;
        wait_clocks(half_clocks / 2);
        ctl_scl = 1'b0;
        if (i > 0) begin
            wait_clocks(half_clocks);
        end
    end
    wait_clocks(hold_clocks);
    ctl_sda = nack;
    wait_clocks(half_clocks - hold_clocks);
    release_scl();
    wait_clocks(half_clocks);
    ctl_scl = 1'b0;
endtask

`endif

// File: tests/tb_i2c_slave.sv
// ############################
// testbench for the I2C target
// controller tasks on wired-AND lines, stream models on both
// sides, write bytes checked as they leave the DUT
// ############################
`default_nettype none

`include "i2c_consts.svh"

module tb_i2c_slave;
    timeunit 1ns;
    timeprecision 1ps;
    import i2c_pkg::*;

    localparam int drain_timeout = 20000;
    localparam int offer_timeout = 20000;

    logic                   clk;
    logic                   rst;
    logic                   ctl_scl;
    logic                   ctl_sda;
    i2c_lines_t             pins;
    i2c_lines_t             drive;
    stream_byte_t           m_byte;
    logic                   m_valid;
    logic                   m_ready;
    stream_byte_t           s_byte;
    logic                   s_valid;
    logic                   s_ready;
    logic                   bus_active;
    logic                   bus_addressed;
    logic [`I2C_ADDR_W-1:0] bus_address;
    logic [`I2C_ADDR_W-1:0] device_address;
    logic [`I2C_ADDR_W-1:0] device_address_mask;

    integer     seed = 12228;
    string      test_name = "reset";
    logic       throttle = 1'b0;
    // expected output beats as {data, last}
    logic [8:0] exp_q[$];
    logic [7:0] wr_data[0:15];
    logic [7:0] rd_data[0:15];

    // a line is low when either side pulls it
    assign pins = {ctl_scl & drive.scl, ctl_sda & drive.sda};

    i2c_slave i2c_slave_inst (
        .clk                 (clk),
        .rst                 (rst),
        .pins                (pins),
        .drive               (drive),
        .m_byte              (m_byte),
        .m_valid             (m_valid),
        .m_ready             (m_ready),
        .s_byte              (s_byte),
        .s_valid             (s_valid),
        .s_ready             (s_ready),
        .bus_active          (bus_active),
        .bus_addressed       (bus_addressed),
        .bus_address         (bus_address),
        .device_address      (device_address),
        .device_address_mask (device_address_mask)
    );

    `include "i2c_master_tasks.svh"

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("error %s %s: expected 0x%0h, actual 0x%0h",
                                test_name, what, expected, actual));
        end
    endtask

    // masked bits must agree while unmasked bits may differ
    function automatic logic addr_match(input logic [6:0] dev, input logic [6:0] mask,
                                        input logic [6:0] rx);
        logic hit;
        hit = 1'b1;
        for (int i = 0; i < 7; i++) begin
            if (mask[i] && (dev[i] != rx[i])) begin
                hit = 1'b0;
            end
        end
        return hit;
    endfunction

    // every written byte in order with last only on the final one
    function automatic void build_write_stream(input int count);
        for (int i = 0; i < count; i++) begin
            exp_q.push_back({wr_data[i], i == count - 1});
        end
    endfunction

    task automatic refill_data;
        logic [31:0] rnd;
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            wr_data[i] = rnd[7:0];
            rd_data[i] = rnd[23:16];
        end
    endtask

    task automatic begin_transfer;
        start_condition();
        check_value("bus_active after start", 1, 32'(bus_active));
    endtask

    task automatic end_transfer;
        stop_condition();
        check_value("bus_active after stop", 0, 32'(bus_active));
        check_value("bus_addressed after stop", 0, 32'(bus_addressed));
    endtask

    task automatic wait_output_drained;
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= drain_timeout) begin
                abort_run("timeout: written bytes never left the output stream");
            end
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        check_value("m_valid after drain", 0, 32'(m_valid));
    endtask

    task automatic run_write(input logic [6:0] addr, input int count);
        logic matched;
        logic ack_bit;
        matched = addr_match(device_address, device_address_mask, addr);
        if (matched) begin
            build_write_stream(count);
        end
        begin_transfer();
        write_byte({addr, 1'b0}, ack_bit);
        // ACK is sda low
        check_value("address ack", 32'(!matched), 32'(ack_bit));
        check_value("bus_addressed", 32'(matched), 32'(bus_addressed));
        if (matched) begin
            check_value("bus_address", 32'(addr), 32'(bus_address));
            for (int i = 0; i < count; i++) begin
                write_byte(wr_data[i], ack_bit);
                check_value("data ack", 0, 32'(ack_bit));
            end
        end
        end_transfer();
        wait_output_drained();
    endtask

    // host side of the input stream with random gaps between bytes
    task automatic offer_bytes(input int count);
        logic [31:0] rnd;
        int          waited;
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            wait_clocks(rnd % 300);
            s_byte  = {rd_data[i], 1'b0};
            s_valid = 1'b1;
            waited  = 0;
            while (!s_ready) begin
                if (waited >= offer_timeout) begin
                    abort_run("timeout: the target never took an offered byte");
                end
                @(negedge clk);
                waited++;
            end
            // s_ready seen high so the transfer happens on the next rising edge
            @(negedge clk);
            s_valid = 1'b0;
        end
    endtask

    task automatic run_read(input int count);
        logic       ack_bit;
        logic [7:0] got;
        begin_transfer();
        write_byte({device_address, 1'b1}, ack_bit);
        check_value("address ack", 0, 32'(ack_bit));
        for (int i = 0; i < count; i++) begin
            read_byte(got, i == count - 1);
            check_value($sformatf("read byte %0d", i), 32'(rd_data[i]), 32'(got));
        end
        end_transfer();
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // output stream sink with long random stalls while throttled
    initial begin
        logic [31:0] rnd;
        m_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (throttle) begin
                rnd = $random(seed);
                m_ready = 1'b0;
                wait_clocks(100 + rnd % 400);
                m_ready = 1'b1;
                wait_clocks(1 + (rnd >> 16) % 8);
            end else begin
                m_ready = 1'b1;
            end
        end
    end

    // every output transfer must match the head of the expected queue
    initial begin
        logic [8:0] exp_beat;
        forever begin
            @(posedge clk);
            if (!rst && m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("unexpected byte on the output stream");
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_value("output byte", 32'(exp_beat), 32'(m_byte));
                end
            end
        end
    end

    initial begin
        rst                 = 1'b1;
        ctl_scl             = 1'b1;
        ctl_sda             = 1'b1;
        s_byte              = '0;
        s_valid             = 1'b0;
        device_address      = 7'h3c;
        device_address_mask = 7'h7f;
        wait_clocks(5);
        rst = 1'b0;
        wait_clocks(20);

        test_name = "exact_write";
        refill_data();
        run_write(7'h3c, 5);

        // ACK bit must read high and nothing reaches the stream
        test_name = "address_mismatch";
        run_write(7'h3d, 0);

        test_name = "masked_match";
        device_address      = 7'h50;
        device_address_mask = 7'h78;
        run_write(7'h53, 2);

        test_name = "read";
        device_address      = 7'h21;
        device_address_mask = 7'h7f;
        refill_data();
        fork
            offer_bytes(6);
            run_read(6);
        join

        // write through clock stretching
        test_name = "back_pressure";
        refill_data();
        throttle = 1'b1;
        run_write(7'h21, 8);
        throttle = 1'b0;

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/i2c_slave.sv
// ############################
// I2C target top level
// pins in, open-drain drive out (0 = pull low);
// write data leaves on m_*, read data is taken from s_*
// ############################
`default_nettype none

`include "i2c_consts.svh"

module i2c_slave (
    input  wire                        clk,
    input  wire                        rst,

    // pin levels in, drive enables out
    input  wire i2c_pkg::i2c_lines_t   pins,
    output i2c_pkg::i2c_lines_t        drive,

    // bytes written by the controller
    output i2c_pkg::stream_byte_t      m_byte,
    output logic                       m_valid,
    input  wire                        m_ready,

    // bytes returned on controller reads
    input  wire i2c_pkg::stream_byte_t s_byte,
    input  wire                        s_valid,
    output logic                       s_ready,

    // status
    output logic                       bus_active,
    output logic                       bus_addressed,
    output logic [`I2C_ADDR_W-1:0]     bus_address,

    // config, mask of all ones for a single address
    input  wire [`I2C_ADDR_W-1:0]      device_address,
    input  wire [`I2C_ADDR_W-1:0]      device_address_mask
);
    import i2c_pkg::*;

    // filtered levels and strobes from monitor to FSM
    bus_events_t events;

    i2c_bus_monitor bus_monitor_inst (
        .clk        (clk),
        .rst        (rst),
        .pins       (pins),
        .events     (events),
        .bus_active (bus_active)
    );

    i2c_slave_fsm slave_fsm_inst (
        .clk                 (clk),
        .rst                 (rst),
        .events              (events),
        .device_address      (device_address),
        .device_address_mask (device_address_mask),
        .drive               (drive),
        .m_byte              (m_byte),
        .m_valid             (m_valid),
        .m_ready             (m_ready),
        .s_byte              (s_byte),
        .s_valid             (s_valid),
        .s_ready             (s_ready),
        .bus_address         (bus_address),
        .bus_addressed       (bus_addressed)
    );

endmodule

`default_nettype wire

// File: src/i2c_slave_fsm.sv
// ############################
// I2C target protocol engine
// address match, byte shifting, ACK drive and clock stretch;
// write bytes leave one byte late so the final one carries last
// ############################
`default_nettype none

`include "i2c_consts.svh"

module i2c_slave_fsm (
    input  wire                        clk,
    input  wire                        rst,
    input  wire i2c_pkg::bus_events_t  events,
    input  wire [`I2C_ADDR_W-1:0]      device_address,
    input  wire [`I2C_ADDR_W-1:0]      device_address_mask,
    output i2c_pkg::i2c_lines_t        drive,
    output i2c_pkg::stream_byte_t      m_byte,
    output logic                       m_valid,
    input  wire                        m_ready,
    input  wire i2c_pkg::stream_byte_t s_byte,
    input  wire                        s_valid,
    output logic                       s_ready,
    output logic [`I2C_ADDR_W-1:0]     bus_address,
    output logic                       bus_addressed
);
    import i2c_pkg::*;

    localparam int cnt_w = $clog2(`I2C_BIT_LAST + 1);
    localparam logic [cnt_w-1:0] bit_reload = cnt_w'(`I2C_BIT_LAST);

    slave_state_t state_q, state_d;

    // shared shift register, address and write bytes in, read bytes out
    logic [`I2C_BYTE_W-1:0] shift_q, shift_d;
    logic [cnt_w-1:0]       bit_cnt_q, bit_cnt_d;

    // write: shift_q holds a complete byte / read: shift_q holds a byte to send
    logic byte_held_q, byte_held_d;
    // write: m_byte loaded but not yet known to be the last one
    logic out_pending_q, out_pending_d;
    logic mode_read_q, mode_read_d;

    // next values of the registered outputs
    i2c_lines_t             drive_d;
    stream_byte_t           m_byte_d;
    logic                   m_valid_d;
    logic                   s_ready_d;
    logic [`I2C_ADDR_W-1:0] bus_address_d;
    logic                   bus_addressed_d;

    logic addr_hit;
    logic scl_low_slot;

    // only masked bits take part in the compare
    assign addr_hit = ((device_address ^ shift_q[`I2C_ADDR_W-1:0])
                       & device_address_mask) == '0;

    // scl just fell, or we are holding it low and may let it go
    assign scl_low_slot = events.scl_fall || !drive.scl;

    always_comb begin
        state_d         = state_q;
        shift_d         = shift_q;
        bit_cnt_d       = bit_cnt_q;
        byte_held_d     = byte_held_q;
        out_pending_d   = out_pending_q;
        mode_read_d     = mode_read_q;
        drive_d         = drive;
        m_byte_d        = m_byte;
        m_valid_d       = m_valid && !m_ready;
        s_ready_d       = 1'b0;
        bus_address_d   = bus_address;
        bus_addressed_d = bus_addressed;

        if (events.start || events.stop) begin
            // transfer ended, the byte waiting in m_byte was the final one
            if (out_pending_q) begin
                m_valid_d     = 1'b1;
                m_byte_d.last = 1'b1;
            end
            byte_held_d     = 1'b0;
            out_pending_d   = 1'b0;
            bus_addressed_d = 1'b0;
            drive_d         = '1;
            bit_cnt_d       = bit_reload;
            state_d         = events.start ? st_address : st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    byte_held_d     = 1'b0;
                    out_pending_d   = 1'b0;
                    bus_addressed_d = 1'b0;
                    drive_d         = '1;
                end

                st_address: begin
                    if (events.scl_rise) begin
                        if (bit_cnt_q != '0) begin
                            // address bits, MSB first
                            shift_d   = {shift_q[`I2C_BYTE_W-2:0], events.sda};
                            bit_cnt_d = bit_cnt_q - 1'b1;
                        end else if (addr_hit) begin
                            // eighth bit is R/W
                            bus_address_d   = shift_q[`I2C_ADDR_W-1:0];
                            mode_read_d     = events.sda;
                            bus_addressed_d = 1'b1;
                            state_d         = st_ack;
                        end else begin
                            // not for us, wait for the next start
                            state_d = st_idle;
                        end
                    end
                end

                st_ack: begin
                    // pull sda low for the ninth clock
                    if (events.scl_fall) begin
                        drive_d.sda = 1'b0;
                        bit_cnt_d   = bit_reload;
                        if (mode_read_q) begin
                            s_ready_d   = 1'b1;
                            byte_held_d = 1'b0;
                            state_d     = st_read_shift;
                        end else begin
                            state_d = st_write_setup;
                        end
                    end
                end

                st_write_setup: begin
                    if (scl_low_slot) begin
                        // ACK done
                        drive_d.sda = 1'b1;
                        if (m_valid && !m_ready) begin
                            // previous byte still stuck on the stream, stretch
                            drive_d.scl = 1'b0;
                        end else begin
                            drive_d.scl = 1'b1;
                            if (byte_held_q) begin
                                m_byte_d.data = shift_q;
                                m_byte_d.last = 1'b0;
                            end
                            byte_held_d   = 1'b0;
                            out_pending_d = byte_held_q;
                            state_d       = st_write_shift;
                        end
                    end
                end

                st_write_shift: begin
                    if (events.scl_rise) begin
                        shift_d = {shift_q[`I2C_BYTE_W-2:0], events.sda};
                        if (bit_cnt_q != '0) begin
                            bit_cnt_d = bit_cnt_q - 1'b1;
                        end else begin
                            // another byte arrived, so the pending one is not last
                            m_valid_d     = m_valid_d || out_pending_q;
                            out_pending_d = 1'b0;
                            byte_held_d   = 1'b1;
                            state_d       = st_ack;
                        end
                    end
                end

                st_read_shift: begin
                    // fetch from the input stream when empty
                    if (s_ready && s_valid) begin
                        shift_d     = s_byte.data;
                        byte_held_d = 1'b1;
                    end else begin
                        s_ready_d = !byte_held_q;
                    end

                    if (scl_low_slot) begin
                        if (!byte_held_q) begin
                            // nothing to send yet
                            drive_d.scl = 1'b0;
                        end else begin
                            drive_d.scl = 1'b1;
                            drive_d.sda = shift_q[`I2C_BYTE_W-1];
                            shift_d     = {shift_q[`I2C_BYTE_W-2:0], 1'b0};
                            if (bit_cnt_q != '0) begin
                                bit_cnt_d = bit_cnt_q - 1'b1;
                            end else begin
                                state_d = st_read_ack_wait;
                            end
                        end
                    end
                end

                st_read_ack_wait: begin
                    // let go of sda after bit 0 so the controller can answer
                    if (events.scl_fall) begin
                        drive_d.sda = 1'b1;
                        state_d     = st_read_ack_sample;
                    end
                end

                st_read_ack_sample: begin
                    if (events.scl_rise) begin
                        if (events.sda) begin
                            // NACK, controller wants no more
                            state_d = st_idle;
                        end else begin
                            bit_cnt_d   = bit_reload;
                            s_ready_d   = 1'b1;
                            byte_held_d = 1'b0;
                            state_d     = st_read_shift;
                        end
                    end
                end

                default: begin
                    state_d = st_idle;
                end
            endcase
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= st_idle;
            bit_cnt_q     <= '0;
            byte_held_q   <= 1'b0;
            out_pending_q <= 1'b0;
            mode_read_q   <= 1'b0;
            drive         <= '1;
            m_valid       <= 1'b0;
            s_ready       <= 1'b0;
            bus_addressed <= 1'b0;
        end else begin
            state_q       <= state_d;
            bit_cnt_q     <= bit_cnt_d;
            byte_held_q   <= byte_held_d;
            out_pending_q <= out_pending_d;
            mode_read_q   <= mode_read_d;
            drive         <= drive_d;
            m_valid       <= m_valid_d;
            s_ready       <= s_ready_d;
            bus_addressed <= bus_addressed_d;
        end
    end

    // data path
    always_ff @(posedge clk) begin
        shift_q     <= shift_d;
        m_byte      <= m_byte_d;
        bus_address <= bus_address_d;
    end

endmodule

`default_nettype wire

// File: src/i2c_bus_monitor.sv
// ############################
// I2C line monitor
// filters scl and sda, produces edge and start/stop strobes
// and tracks whether any transfer is in progress on the bus
// ############################
`default_nettype none

module i2c_bus_monitor (
    input  wire                      clk,
    input  wire                      rst,
    input  wire i2c_pkg::i2c_lines_t pins,
    output i2c_pkg::bus_events_t     events,
    output logic                     bus_active
);
    import i2c_pkg::*;

    logic scl_level;
    logic sda_level;

    i2c_glitch_filter scl_filter_inst (
        .clk   (clk),
        .rst   (rst),
        .raw   (pins.scl),
        .level (scl_level)
    );

    i2c_glitch_filter sda_filter_inst (
        .clk   (clk),
        .rst   (rst),
        .raw   (pins.sda),
        .level (sda_level)
    );

    // events.scl / events.sda lag the filter by one cycle and serve
    // as the previous level for edge detection
    always_ff @(posedge clk) begin
        if (rst) begin
            events     <= '{scl: 1'b1, sda: 1'b1, default: 1'b0};
            bus_active <= 1'b0;
        end else begin
            events.scl      <= scl_level;
            events.sda      <= sda_level;
            events.scl_rise <= scl_level & ~events.scl;
            events.scl_fall <= ~scl_level & events.scl;
            // sda moves while scl stays high
            events.start    <= ~sda_level & events.sda & scl_level & events.scl;
            events.stop     <= sda_level & ~events.sda & scl_level & events.scl;

            if (events.start) begin
                bus_active <= 1'b1;
            end else if (events.stop) begin
                bus_active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/i2c_glitch_filter.sv
// ############################
// run-length filter for one I2C line
// output follows the input only after it has been stable
// for the full filter length
// ############################
`default_nettype none

`include "i2c_consts.svh"

module i2c_glitch_filter (
    input  wire  clk,
    input  wire  rst,
    input  wire  raw,
    output logic level
);

    // recent samples, newest in bit 0
    logic [`I2C_FILTER_LEN-1:0] hist_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            // idle bus reads high
            hist_q <= '1;
            level  <= 1'b1;
        end else begin
            hist_q <= {hist_q[`I2C_FILTER_LEN-2:0], raw};

            // all samples high
            if (&hist_q) begin
                level <= 1'b1;
            end
            // all samples low
            else if (~|hist_q) begin
                level <= 1'b0;
            end
            // mixed samples keep the old level, so short pulses vanish
        end
    end

endmodule

`default_nettype wire

// File: src/i2c_pkg.sv
// ############################
// shared types for the I2C target
// import inside module bodies, scoped names in port lists
// ############################
`default_nettype none

`include "i2c_consts.svh"

package i2c_pkg;

    // target FSM states
    typedef enum logic [2:0] {
        st_idle,
        st_address,
        st_ack,
        st_write_setup,
        st_write_shift,
        st_read_shift,
        st_read_ack_wait,
        st_read_ack_sample
    } slave_state_t;

    // one bit per line, 1 = high / released
    typedef struct packed {
        logic scl;
        logic sda;
    } i2c_lines_t;

    // filtered levels plus single-cycle strobes
    typedef struct packed {
        logic scl;
        logic sda;
        logic scl_rise;
        logic scl_fall;
        logic start;
        logic stop;
    } bus_events_t;

    // stream beat, last ignored on the input side
    typedef struct packed {
        logic [`I2C_BYTE_W-1:0] data;
        logic                   last;
    } stream_byte_t;

endpackage

`default_nettype wire

// File: src/i2c_consts.svh
// ############################
// widths and timing constants for the I2C target
// include in any file that sizes a bus or a counter
// ############################
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// equal samples needed before a filtered line may change
`define I2C_FILTER_LEN 4

// 7-bit addressing only
`define I2C_ADDR_W 7

// data byte on the wire and on both streams
`define I2C_BYTE_W 8

// bit counter reload, counts down to zero over one byte
`define I2C_BIT_LAST 7

`endif
